// File: Bender.yml
package:
  name: sifh

sources:
  # design, package first
  - files:
      - hw/sifh_pkg.sv
      - hw/his_rd_if.sv
      - hw/bin_mapper.sv
      - hw/his_builder.sv
      - hw/peak_search.sv
      - hw/sifh_top.sv

  # simulation only
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/sifh_tb.sv

// File: hw/bin_mapper.sv
`timescale 1ns/100ps

module bin_mapper (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            hit_valid,
    input  sifh_pkg::ts_t   hit_ts,
    output logic            map_valid,
    output sifh_pkg::bin_t  map_bin,
    output logic            map_in_range
);

    // timestamp with the sub-bin bits dropped
    logic [sifh_pkg::SBIN_W-1:0] shifted;
    logic                        in_range;

    assign shifted = hit_ts[sifh_pkg::TS_W-1:sifh_pkg::BIN_SHIFT];
    // anything at or past NB falls outside the histogram
    assign in_range = (shifted < sifh_pkg::NB);

    // strobe delayed by one cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            map_valid <= 1'b0;
        end else begin
            map_valid <= hit_valid;
        end
    end

    // payload, only loaded on a hit
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            map_in_range <= in_range;
            if (in_range) begin
                map_bin <= shifted[sifh_pkg::BIN_W-1:0];
            end else begin
                // out of range bins read as zero
                map_bin <= '0;
            end
        end
    end

endmodule

// File: hw/his_builder.sv
`timescale 1ns/100ps

module his_builder (
    input  logic             clk,
    input  logic             combin_res,
    input  logic             map_valid,
    input  sifh_pkg::bin_t   map_bin,
    input  logic             map_in_range,
    output logic             count_valid,
    output sifh_pkg::pix_t   count_pixel,
    output sifh_pkg::bin_t   count_bin,
    output sifh_pkg::cnt_t   bin_count,
    output logic             bank,
    his_rd_if.builder        rd
);

    // sequencing counters, input inside pixel inside acquisition
    logic [sifh_pkg::DATA_W-1:0] input_cnt;
    sifh_pkg::pix_t              pixel_cnt;
    logic [sifh_pkg::ACQ_W-1:0]  acq_cnt;

    logic last_input;
    logic last_pixel;
    logic last_acq;
    logic frame_end;

    // two banks, one filling while the other is scanned
    sifh_pkg::cnt_t hist [2][sifh_pkg::HIS_DEPTH];

    logic [sifh_pkg::ADDR_W-1:0] wr_addr;
    logic [sifh_pkg::ADDR_W-1:0] rd_addr;
    logic                        rd_bank;
    logic                        wr_en;

    assign last_input = (input_cnt == sifh_pkg::DATA_NUM - 1);
    assign last_pixel = (pixel_cnt == sifh_pkg::PIXEL_NUM - 1);
    assign last_acq   = (acq_cnt == sifh_pkg::ACQ_NUM - 1);
    // last hit of the frame, in range or not
    assign frame_end  = map_valid && last_input && last_pixel && last_acq;

    // pixel picks the histogram, bin the entry inside it
    assign wr_addr = {pixel_cnt, map_bin};
    assign wr_en   = map_valid && map_in_range;

    assign rd_addr    = {rd.rd_pixel, rd.rd_bin};
    assign rd_bank    = ~bank;
    // async read of the finished bank
    assign rd.rd_data = hist[rd_bank][rd_addr];

    // every valid hit advances the sequence
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            input_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (map_valid) begin
            if (!last_input) begin
                input_cnt <= input_cnt + 1'b1;
            end else begin
                input_cnt <= '0;
                if (!last_pixel) begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end else begin
                    pixel_cnt <= '0;
                    if (!last_acq) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        acq_cnt <= '0;
                    end
                end
            end
        end
    end

    // bank select and frame strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bank          <= 1'b0;
            rd.frame_done <= 1'b0;
            count_valid   <= 1'b0;
        end else begin
            // swap on the same edge as the last write
            if (frame_end) begin
                bank <= ~bank;
            end
            rd.frame_done <= frame_end;
            count_valid   <= wr_en;
        end
    end

    // bin increment into the active bank, read-and-clear on the other
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int b = 0; b < 2; b++) begin
                for (int a = 0; a < sifh_pkg::HIS_DEPTH; a++) begin
                    hist[b][a] <= '0;
                end
            end
        end else begin
            if (wr_en) begin
                hist[bank][wr_addr] <= hist[bank][wr_addr] + 1'b1;
            end
            // never the same bank as the write
            if (rd.rd_en) begin
                hist[rd_bank][rd_addr] <= '0;
            end
        end
    end

    // report the updated count one cycle after the write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            count_pixel <= pixel_cnt;
            count_bin   <= map_bin;
            bin_count   <= hist[bank][wr_addr] + 1'b1;
        end
    end

endmodule

// File: hw/his_rd_if.sv
`timescale 1ns/100ps

interface his_rd_if;

    // frame end strobe from the builder
    logic               frame_done;
    // read-and-clear port on the bank not being filled
    logic               rd_en;
    sifh_pkg::pix_t     rd_pixel;
    sifh_pkg::bin_t     rd_bin;
    // combinational, valid with rd_en
    sifh_pkg::cnt_t     rd_data;

    modport builder (
        output frame_done,
        output rd_data,
        input  rd_en,
        input  rd_pixel,
        input  rd_bin
    );

    modport search (
        input  frame_done,
        input  rd_data,
        output rd_en,
        output rd_pixel,
        output rd_bin
    );

endinterface

// File: hw/peak_search.sv
`timescale 1ns/100ps

module peak_search (
    input  logic            clk,
    input  logic            combin_res,
    his_rd_if.search        rd,
    output logic            peak_valid,
    output sifh_pkg::pix_t  peak_pixel,
    output sifh_pkg::bin_t  peak_bin,
    output sifh_pkg::cnt_t  peak_count
);

    // scan position, pixel in the upper bits
    logic                        busy;
    logic [sifh_pkg::ADDR_W-1:0] scan_cnt;
    logic                        scan_last;
    logic                        bin_first;
    logic                        bin_last;

    // running maximum within the current pixel
    sifh_pkg::cnt_t max_cnt;
    sifh_pkg::bin_t max_bin;
    // maximum once the current read is folded in
    sifh_pkg::cnt_t cand_cnt;
    sifh_pkg::bin_t cand_bin;

    assign rd.rd_en    = busy;
    assign rd.rd_pixel = scan_cnt[sifh_pkg::ADDR_W-1:sifh_pkg::BIN_W];
    assign rd.rd_bin   = scan_cnt[sifh_pkg::BIN_W-1:0];

    assign bin_first = (rd.rd_bin == '0);
    assign bin_last  = (rd.rd_bin == sifh_pkg::NB - 1);
    assign scan_last = (scan_cnt == sifh_pkg::HIS_DEPTH - 1);

    // first bin restarts the max, later bins need a strictly greater count
    // so ties keep the lower bin
    always_comb begin
        if (bin_first || (rd.rd_data > max_cnt)) begin
            cand_cnt = rd.rd_data;
            cand_bin = rd.rd_bin;
        end else begin
            cand_cnt = max_cnt;
            cand_bin = max_bin;
        end
    end

    // scan control
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy       <= 1'b0;
            scan_cnt   <= '0;
            peak_valid <= 1'b0;
        end else begin
            peak_valid <= busy && bin_last;
            if (rd.frame_done) begin
                // start one cycle after the strobe
                busy     <= 1'b1;
                scan_cnt <= '0;
            end else if (busy) begin
                scan_cnt <= scan_cnt + 1'b1;
                if (scan_last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    // running max and per-pixel result
    always_ff @(posedge clk) begin
        if (busy) begin
            max_cnt <= cand_cnt;
            max_bin <= cand_bin;
            if (bin_last) begin
                peak_pixel <= rd.rd_pixel;
                peak_bin   <= cand_bin;
                peak_count <= cand_cnt;
            end
        end
    end

endmodule

// File: hw/sifh_pkg.sv
package sifh_pkg;

    // timestamp and bin geometry
    localparam int TS_W      = 8;
    // low timestamp bits folded into one bin
    localparam int BIN_SHIFT = 2;
    localparam int SBIN_W    = TS_W - BIN_SHIFT;
    localparam int NB        = 16;
    localparam int BIN_W     = 4;

    // hit sequencing, innermost first
    localparam int DATA_NUM  = 2;
    localparam int DATA_W    = 1;
    localparam int PIXEL_NUM = 4;
    localparam int PIX_W     = 2;
    localparam int ACQ_NUM   = 8;
    localparam int ACQ_W     = 3;
    localparam int FRAME_HITS = DATA_NUM * PIXEL_NUM * ACQ_NUM;

    // one bank holds every pixel histogram back to back
    localparam int ADDR_W    = PIX_W + BIN_W;
    localparam int HIS_DEPTH = PIXEL_NUM * NB;

    // bin count, must hold DATA_NUM * ACQ_NUM
    localparam int CNT_W     = 5;

    typedef logic [TS_W-1:0]  ts_t;
    typedef logic [BIN_W-1:0] bin_t;
    typedef logic [PIX_W-1:0] pix_t;
    typedef logic [CNT_W-1:0] cnt_t;

endpackage

// File: hw/sifh_top.sv
`timescale 1ns/100ps

module sifh_top (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            hit_valid,
    input  sifh_pkg::ts_t   hit_ts,
    output logic            count_valid,
    output sifh_pkg::pix_t  count_pixel,
    output sifh_pkg::bin_t  count_bin,
    output sifh_pkg::cnt_t  bin_count,
    output logic            bank,
    output logic            frame_done,
    output logic            peak_valid,
    output sifh_pkg::pix_t  peak_pixel,
    output sifh_pkg::bin_t  peak_bin,
    output sifh_pkg::cnt_t  peak_count
);

    // mapper to builder
    logic           map_valid;
    sifh_pkg::bin_t map_bin;
    logic           map_in_range;

    // builder to peak search
    his_rd_if rd_if ();

    // frame strobe also goes off chip
    assign frame_done = rd_if.frame_done;

    bin_mapper i_bin_mapper (
        .clk          (clk),
        .combin_res   (combin_res),
        .hit_valid    (hit_valid),
        .hit_ts       (hit_ts),
        .map_valid    (map_valid),
        .map_bin      (map_bin),
        .map_in_range (map_in_range)
    );

    his_builder i_his_builder (
        .clk          (clk),
        .combin_res   (combin_res),
        .map_valid    (map_valid),
        .map_bin      (map_bin),
        .map_in_range (map_in_range),
        .count_valid  (count_valid),
        .count_pixel  (count_pixel),
        .count_bin    (count_bin),
        .bin_count    (bin_count),
        .bank         (bank),
        .rd           (rd_if.builder)
    );

    peak_search i_peak_search (
        .clk          (clk),
        .combin_res   (combin_res),
        .rd           (rd_if.search),
        .peak_valid   (peak_valid),
        .peak_pixel   (peak_pixel),
        .peak_bin     (peak_bin),
        .peak_count   (peak_count)
    );

endmodule

// File: sources.f
hw/sifh_pkg.sv
hw/his_rd_if.sv
hw/bin_mapper.sv
hw/his_builder.sv
hw/peak_search.sv
hw/sifh_top.sv
test/tb_clk_gen.sv
test/sifh_tb.sv

// File: test/sifh_tb.sv
`timescale 1ns/100ps

module sifh_tb;

    localparam int SEED           = 22564;
    // inputs change this long after the rising edge
    localparam int DRIVE_DLY      = 2;
    localparam int RUN_FRAMES     = 4;
    localparam int RUN_HITS       = RUN_FRAMES * sifh_pkg::FRAME_HITS;
    // last hit to last peak of its frame is 67 cycles
    localparam int DRAIN_CYCLES   = sifh_pkg::HIS_DEPTH + 24;
    // twice the mean hit spacing plus all scans and some slack
    localparam int TIMEOUT_CYCLES = 4 * RUN_HITS + RUN_FRAMES * sifh_pkg::HIS_DEPTH + 220;

    logic           clk;
    logic           combin_res;
    logic           hit_valid;
    sifh_pkg::ts_t  hit_ts;
    logic           count_valid;
    sifh_pkg::pix_t count_pixel;
    sifh_pkg::bin_t count_bin;
    sifh_pkg::cnt_t bin_count;
    logic           bank;
    logic           frame_done;
    logic           peak_valid;
    sifh_pkg::pix_t peak_pixel;
    sifh_pkg::bin_t peak_bin;
    sifh_pkg::cnt_t peak_count;

    // cycles since reset release
    int   cyc;
    logic exp_bank;

    // model sequencing and histograms
    int m_input;
    int m_pixel;
    int m_acq;
    int m_bank;
    int m_hist [2][sifh_pkg::PIXEL_NUM][sifh_pkg::NB];

    // expected events keyed by the cycle they must show up
    int             cnt_due_q [$];
    sifh_pkg::pix_t cnt_pix_q [$];
    sifh_pkg::bin_t cnt_bin_q [$];
    sifh_pkg::cnt_t cnt_val_q [$];
    int             fd_due_q [$];
    int             pk_due_q [$];
    sifh_pkg::pix_t pk_pix_q [$];
    sifh_pkg::bin_t pk_bin_q [$];
    sifh_pkg::cnt_t pk_val_q [$];

    tb_clk_gen #(.PERIOD_NS(40)) i_clk_gen (.clk(clk));

    sifh_top i_dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .hit_valid   (hit_valid),
        .hit_ts      (hit_ts),
        .count_valid (count_valid),
        .count_pixel (count_pixel),
        .count_bin   (count_bin),
        .bin_count   (bin_count),
        .bank        (bank),
        .frame_done  (frame_done),
        .peak_valid  (peak_valid),
        .peak_pixel  (peak_pixel),
        .peak_bin    (peak_bin),
        .peak_count  (peak_count)
    );

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        abort_run();
    endtask

    // single bit strobe against its expected level
    task automatic expect_strobe(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_mismatch($sformatf("%s is %b, expected %b", name, act, exp));
        end
    endtask

    task automatic check_count(input sifh_pkg::pix_t exp_pix, input sifh_pkg::bin_t exp_bin,
                               input sifh_pkg::cnt_t exp_cnt);
        if (count_pixel !== exp_pix || count_bin !== exp_bin || bin_count !== exp_cnt) begin
            report_mismatch($sformatf("count pixel %0d bin %0d value %0d, expected %0d %0d %0d",
                count_pixel, count_bin, bin_count, exp_pix, exp_bin, exp_cnt));
        end
    endtask

    task automatic check_peak(input sifh_pkg::pix_t exp_pix, input sifh_pkg::bin_t exp_bin,
                              input sifh_pkg::cnt_t exp_cnt);
        if (peak_pixel !== exp_pix || peak_bin !== exp_bin || peak_count !== exp_cnt) begin
            report_mismatch($sformatf("peak pixel %0d bin %0d count %0d, expected %0d %0d %0d",
                peak_pixel, peak_bin, peak_count, exp_pix, exp_bin, exp_cnt));
        end
    endtask

    task automatic check_bank(input logic exp_val);
        if (bank !== exp_val) begin
            report_mismatch($sformatf("bank is %b, expected %b", bank, exp_val));
        end
    endtask

    // peaks of the finished bank then empty it as the scan will
    task automatic close_frame(input int done_due);
        int best;
        int best_bin;
        fd_due_q.push_back(done_due);
        for (int p = 0; p < sifh_pkg::PIXEL_NUM; p++) begin
            best     = 0;
            best_bin = 0;
            // strictly greater keeps the lowest bin on a tie
            for (int b = 0; b < sifh_pkg::NB; b++) begin
                if (m_hist[m_bank][p][b] > best) begin
                    best     = m_hist[m_bank][p][b];
                    best_bin = b;
                end
                m_hist[m_bank][p][b] = 0;
            end
            // scan starts a cycle after frame_done with 16 reads per pixel
            pk_due_q.push_back(done_due + sifh_pkg::NB + 1 + sifh_pkg::NB * p);
            pk_pix_q.push_back(sifh_pkg::pix_t'(p));
            pk_bin_q.push_back(sifh_pkg::bin_t'(best_bin));
            pk_val_q.push_back(sifh_pkg::cnt_t'(best));
        end
        m_bank = 1 - m_bank;
    endtask

    // hit driven this cycle has its results due two edges later
    task automatic model_hit(input sifh_pkg::ts_t ts);
        int shifted;
        int due;
        shifted = ts >> sifh_pkg::BIN_SHIFT;
        due     = cyc + 2;
        if (shifted < sifh_pkg::NB) begin
            m_hist[m_bank][m_pixel][shifted]++;
            cnt_due_q.push_back(due);
            cnt_pix_q.push_back(sifh_pkg::pix_t'(m_pixel));
            cnt_bin_q.push_back(sifh_pkg::bin_t'(shifted));
            cnt_val_q.push_back(sifh_pkg::cnt_t'(m_hist[m_bank][m_pixel][shifted]));
        end
        // out of range hits still count here
        m_input++;
        if (m_input == sifh_pkg::DATA_NUM) begin
            m_input = 0;
            m_pixel++;
        end
        if (m_pixel == sifh_pkg::PIXEL_NUM) begin
            m_pixel = 0;
            m_acq++;
        end
        if (m_acq == sifh_pkg::ACQ_NUM) begin
            m_acq = 0;
            close_frame(due);
        end
    endtask

    // all registered outputs just after the edge
    task automatic sample_outputs();
        if (cnt_due_q.size() > 0 && cnt_due_q[0] == cyc) begin
            expect_strobe("count_valid", 1'b1, count_valid);
            void'(cnt_due_q.pop_front());
            check_count(cnt_pix_q.pop_front(), cnt_bin_q.pop_front(), cnt_val_q.pop_front());
        end else begin
            expect_strobe("count_valid", 1'b0, count_valid);
        end
        if (fd_due_q.size() > 0 && fd_due_q[0] == cyc) begin
            expect_strobe("frame_done", 1'b1, frame_done);
            void'(fd_due_q.pop_front());
            // bank swaps on the same edge
            exp_bank = ~exp_bank;
        end else begin
            expect_strobe("frame_done", 1'b0, frame_done);
        end
        check_bank(exp_bank);
        if (pk_due_q.size() > 0 && pk_due_q[0] == cyc) begin
            expect_strobe("peak_valid", 1'b1, peak_valid);
            void'(pk_due_q.pop_front());
            check_peak(pk_pix_q.pop_front(), pk_bin_q.pop_front(), pk_val_q.pop_front());
        end else begin
            expect_strobe("peak_valid", 1'b0, peak_valid);
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        cyc++;
        sample_outputs();
    endtask

    task automatic apply_reset();
        combin_res = 1'b0;
        hit_valid  = 1'b0;
        hit_ts     = '0;
        cyc        = 0;
        exp_bank   = 1'b0;
        m_input    = 0;
        m_pixel    = 0;
        m_acq      = 0;
        m_bank     = 0;
        for (int k = 0; k < 2; k++) begin
            for (int p = 0; p < sifh_pkg::PIXEL_NUM; p++) begin
                for (int b = 0; b < sifh_pkg::NB; b++) begin
                    m_hist[k][p][b] = 0;
                end
            end
        end
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        combin_res = 1'b1;
        // idle state straight out of reset
        expect_strobe("count_valid after reset", 1'b0, count_valid);
        expect_strobe("frame_done after reset", 1'b0, frame_done);
        expect_strobe("peak_valid after reset", 1'b0, peak_valid);
        check_bank(1'b0);
    endtask

    // main stimulus
    initial begin
        int            hits_sent;
        logic          fire;
        sifh_pkg::ts_t ts;
        combin_res = 1'b0;
        hit_valid  = 1'b0;
        hit_ts     = '0;
        void'($urandom(SEED));
        apply_reset();
        hits_sent = 0;
        while (hits_sent < RUN_HITS) begin
            // a hit about every other cycle and a quarter of them in range
            fire      = (($urandom % 2) == 1);
            ts        = sifh_pkg::ts_t'($urandom_range((1 << sifh_pkg::TS_W) - 1, 0));
            hit_valid = fire;
            hit_ts    = ts;
            if (fire) begin
                model_hit(ts);
                hits_sent++;
            end
            step_cycle();
        end
        hit_valid = 1'b0;
        hit_ts    = '0;
        repeat (DRAIN_CYCLES) step_cycle();
        if (cnt_due_q.size() != 0 || fd_due_q.size() != 0 || pk_due_q.size() != 0) begin
            $display("Run ended with expected counts, frame ends or peaks never seen");
            abort_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    // hang guard
    initial begin
        int tmo_cnt;
        tmo_cnt = 0;
        while (tmo_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            tmo_cnt++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        abort_run();
    end

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule
